// ==== source/sram_bridge_pkg.sv ====
// Shared definitions for the bus to byte-wide SRAM bridge
// RAM geometry, bus width, write retry limit and sequencer states

package sram_bridge_pkg;

	// ============================================================
	// Geometry
	// ============================================================

	// Byte address width of the external RAM (512 K locations)
	localparam int RAM_ADDR_W = 19;

	// The RAM moves one byte per access
	localparam int RAM_DATA_W = 8;

	// Data width of the system bus
	localparam int BUS_DATA_W = 32;

	// Byte lanes in one bus word
	localparam int LANES = BUS_DATA_W / RAM_DATA_W;

	// ============================================================
	// Write verification
	// ============================================================

	// Extra write attempts per byte before the RAM is flagged as bad
	localparam int MAX_RETRIES = 10;

	// Sequencer states
	// Reads take RD_SETUP and RD_SAMPLE per byte
	// Writes take the five WR_ states per attempt
	typedef enum logic [3:0] {
		IDLE,
		RD_SETUP,
		RD_SAMPLE,
		WR_DRIVE,
		WR_PULSE,
		WR_RELEASE,
		WR_TURN,
		WR_VERIFY,
		DONE
	} seq_state_e;

endpackage

// ==== source/bus_request_decode.sv ====
// Bus request qualification and capture
// Converts byte selects into a first RAM address and a byte count
// Signals the end of each served bus cycle

`timescale 1ns/1ps

module bus_request_decode import sram_bridge_pkg::*; (
	input  logic                    clk_i,
	input  logic                    rst_i,
	input  logic                    cs_i,
	input  logic                    cyc_i,
	input  logic                    stb_i,
	input  logic                    we_i,
	input  logic [LANES-1:0]        sel_i,
	input  logic [BUS_DATA_W-1:0]   adr_i,
	input  logic [BUS_DATA_W-1:0]   dat_i,
	input  logic                    req_ready_i,
	output logic                    req_valid_o,
	output logic                    req_we_o,
	output logic [RAM_ADDR_W-1:0]   req_adr_o,
	output logic [2:0]              req_count_o,
	output logic [BUS_DATA_W-1:0]   req_wdat_o,
	output logic                    cycle_end_o
);

	// A request is only present while all three qualifiers are high
	logic qual;
	// Set once this bus cycle has produced its request
	logic served_q;
	logic [$clog2(LANES)-1:0] first_lane;
	logic [$clog2(LANES)-1:0] last_lane;
	logic any_sel;

	assign qual = cs_i & cyc_i & stb_i;

	// Find the lowest and highest selected lanes
	// Scanning down gives the lowest lane the last word on first_lane
	always_comb begin
		first_lane = '0;
		last_lane  = '0;
		for (int i = LANES - 1; i >= 0; i--) begin
			if (sel_i[i])
				first_lane = i[$clog2(LANES)-1:0];
		end
		for (int i = 0; i < LANES; i++) begin
			if (sel_i[i])
				last_lane = i[$clog2(LANES)-1:0];
		end
	end

	assign any_sel = |sel_i;

	// ============================================================
	// Handshake and cycle tracking
	// ============================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			req_valid_o <= 1'b0;
			served_q    <= 1'b0;
			cycle_end_o <= 1'b0;
		end else begin
			cycle_end_o <= 1'b0;
			// Sequencer took the request
			if (req_valid_o && req_ready_i)
				req_valid_o <= 1'b0;
			if (qual && !served_q) begin
				req_valid_o <= 1'b1;
				served_q    <= 1'b1;
			end else if (served_q && !qual && !req_valid_o) begin
				// Master released a cycle that was handed off
				served_q    <= 1'b0;
				cycle_end_o <= 1'b1;
			end
		end
	end

	// Request fields are captured once per bus cycle
	// The span runs from the lowest to the highest lane, gaps included
	always_ff @(posedge clk_i) begin
		if (qual && !served_q) begin
			req_we_o    <= we_i;
			req_wdat_o  <= dat_i;
			req_adr_o   <= {adr_i[RAM_ADDR_W-1:2], first_lane};
			req_count_o <= any_sel ? 3'(last_lane - first_lane) + 3'd1 : 3'd0;
		end
	end

endmodule

// ==== source/sram_byte_sequencer.sv ====
// Byte sequencer for the asynchronous SRAM
// Drives CE, WE, OE and the data direction for each byte
// Writes are read back and repeated on mismatch up to the retry limit

`timescale 1ns/1ps

module sram_byte_sequencer import sram_bridge_pkg::*; (
	input  logic                    clk_i,
	input  logic                    rst_i,
	input  logic                    req_valid_i,
	input  logic                    req_we_i,
	input  logic [RAM_ADDR_W-1:0]   req_adr_i,
	input  logic [2:0]              req_count_i,
	input  logic [BUS_DATA_W-1:0]   req_wdat_i,
	output logic                    req_ready_o,
	output logic                    ram_ce_n_o,
	output logic                    ram_we_n_o,
	output logic                    ram_oe_n_o,
	output logic                    mem_t_o,
	output logic [RAM_ADDR_W-1:0]   mem_adr_o,
	output logic [RAM_DATA_W-1:0]   mem_db_o,
	input  logic [RAM_DATA_W-1:0]   mem_db_i,
	output logic                    rd_byte_valid_o,
	output logic [RAM_DATA_W-1:0]   rd_byte_o,
	output logic [1:0]              rd_lane_o,
	output logic                    seq_done_o,
	output logic                    seq_bad_o
);

	seq_state_e state_q;
	seq_state_e state_d;

	// Bytes still to go in this request
	logic [2:0] remain_q;
	// Failed attempts on the current byte
	logic [$clog2(MAX_RETRIES+1)-1:0] retry_q;
	logic bad_q;
	logic [BUS_DATA_W-1:0] wdat_q;

	logic last_byte;
	logic mismatch;
	logic give_up;
	// Repeat the same byte after a failed read-back
	logic retry_write;
	// The current byte is finished and the address steps on
	logic byte_adv;

	assign last_byte   = (remain_q == 3'd1);
	assign mismatch    = (mem_db_i != mem_db_o);
	assign give_up     = (retry_q == MAX_RETRIES);
	assign retry_write = (state_q == WR_VERIFY) && mismatch && !give_up;
	assign byte_adv    = (state_q == RD_SAMPLE) || ((state_q == WR_VERIFY) && !retry_write);

	// Accept a new request only when idle
	assign req_ready_o = (state_q == IDLE);
	assign seq_done_o  = (state_q == DONE);
	assign seq_bad_o   = bad_q;

	// Write byte follows the lane in the low address bits
	assign mem_db_o = wdat_q[mem_adr_o[1:0]*RAM_DATA_W +: RAM_DATA_W];

	// ============================================================
	// Next state
	// ============================================================

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (req_valid_i) begin
					// An empty select still opens and closes CE
					if (req_count_i == 3'd0)
						state_d = DONE;
					else if (req_we_i)
						state_d = WR_DRIVE;
					else
						state_d = RD_SETUP;
				end
			end
			RD_SETUP:   state_d = RD_SAMPLE;
			RD_SAMPLE:  state_d = last_byte ? DONE : RD_SETUP;
			WR_DRIVE:   state_d = WR_PULSE;
			WR_PULSE:   state_d = WR_RELEASE;
			WR_RELEASE: state_d = WR_TURN;
			WR_TURN:    state_d = WR_VERIFY;
			WR_VERIFY: begin
				if (retry_write || !last_byte)
					state_d = WR_DRIVE;
				else
					state_d = DONE;
			end
			DONE:       state_d = IDLE;
			default:    state_d = IDLE;
		endcase
	end

	// ============================================================
	// RAM control pins
	// ============================================================

	// Pins are registered from the next state so they line up with the state
	// WE is low during WR_DRIVE and WR_PULSE and data is held one more cycle
	// The bus turns to input for the read-back in WR_TURN and WR_VERIFY
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ram_ce_n_o <= 1'b1;
			ram_we_n_o <= 1'b1;
			ram_oe_n_o <= 1'b1;
			mem_t_o    <= 1'b1;
		end else begin
			ram_ce_n_o <= (state_d == IDLE);
			ram_we_n_o <= !(state_d inside {WR_DRIVE, WR_PULSE});
			ram_oe_n_o <= !(state_d inside {RD_SETUP, RD_SAMPLE, WR_TURN, WR_VERIFY});
			mem_t_o    <= !(state_d inside {WR_DRIVE, WR_PULSE, WR_RELEASE});
		end
	end

	// ============================================================
	// Control state
	// ============================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q         <= IDLE;
			remain_q        <= 3'd0;
			retry_q         <= '0;
			bad_q           <= 1'b0;
			rd_byte_valid_o <= 1'b0;
		end else begin
			state_q         <= state_d;
			rd_byte_valid_o <= (state_q == RD_SAMPLE);
			if (state_q == IDLE && req_valid_i) begin
				remain_q <= req_count_i;
				retry_q  <= '0;
				bad_q    <= 1'b0;
			end else if (retry_write) begin
				retry_q <= retry_q + 1'b1;
			end else if (byte_adv) begin
				remain_q <= remain_q - 3'd1;
				retry_q  <= '0;
				// Still failing after the last retry marks the request bad
				if (state_q == WR_VERIFY && mismatch)
					bad_q <= 1'b1;
			end
		end
	end

	// Address, write word and read byte registers
	always_ff @(posedge clk_i) begin
		if (state_q == IDLE && req_valid_i) begin
			mem_adr_o <= req_adr_i;
			wdat_q    <= req_wdat_i;
		end else if (byte_adv) begin
			mem_adr_o[1:0] <= mem_adr_o[1:0] + 2'd1;
		end
		// Data has had the whole setup cycle to settle
		if (state_q == RD_SAMPLE) begin
			rd_byte_o <= mem_db_i;
			rd_lane_o <= mem_adr_o[1:0];
		end
	end

endmodule

// ==== source/read_word_assembly.sv ====
// Read word assembly and bus response
// Places read bytes in their lanes and owns ack and the bad RAM flag

`timescale 1ns/1ps

module read_word_assembly import sram_bridge_pkg::*; (
	input  logic                    clk_i,
	input  logic                    rst_i,
	input  logic                    rd_byte_valid_i,
	input  logic [RAM_DATA_W-1:0]   rd_byte_i,
	input  logic [1:0]              rd_lane_i,
	input  logic                    seq_done_i,
	input  logic                    seq_bad_i,
	input  logic                    cycle_end_i,
	output logic [BUS_DATA_W-1:0]   dat_o,
	output logic                    ack_o,
	output logic                    badram_o
);

	logic [BUS_DATA_W-1:0] word_q;
	logic [BUS_DATA_W-1:0] word_d;
	// High until the first byte of a request arrives
	logic fresh_q;

	// The first byte starts from zero so lanes outside the span read as zero
	// The last byte can arrive together with seq_done
	always_comb begin
		word_d = fresh_q ? '0 : word_q;
		if (rd_byte_valid_i)
			word_d[rd_lane_i*RAM_DATA_W +: RAM_DATA_W] = rd_byte_i;
	end

	always_ff @(posedge clk_i) begin
		if (rd_byte_valid_i)
			word_q <= word_d;
	end

	// ============================================================
	// Response
	// ============================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			fresh_q  <= 1'b1;
			ack_o    <= 1'b0;
			badram_o <= 1'b0;
			dat_o    <= '0;
		end else begin
			if (seq_done_i) begin
				// Writes and empty selects publish zero
				dat_o    <= word_d;
				ack_o    <= 1'b1;
				badram_o <= seq_bad_i;
				fresh_q  <= 1'b1;
			end else if (rd_byte_valid_i) begin
				fresh_q <= 1'b0;
			end
			// Master has released the cycle
			if (cycle_end_i) begin
				ack_o    <= 1'b0;
				badram_o <= 1'b0;
			end
		end
	end

endmodule

// ==== source/sram_bridge_top.sv ====
// Top level of the bus to SRAM bridge
// Connects request decode, byte sequencer and word assembly

`timescale 1ns/1ps

module sram_bridge_top import sram_bridge_pkg::*; (
	input  logic                    clk_i,
	input  logic                    rst_i,
	// System bus
	input  logic                    cs_i,
	input  logic                    cyc_i,
	input  logic                    stb_i,
	input  logic                    we_i,
	input  logic [LANES-1:0]        sel_i,
	input  logic [BUS_DATA_W-1:0]   adr_i,
	input  logic [BUS_DATA_W-1:0]   dat_i,
	output logic [BUS_DATA_W-1:0]   dat_o,
	output logic                    ack_o,
	output logic                    badram_o,
	// RAM pins whose pad buffers sit outside and follow mem_t_o
	output logic                    ram_ce_n_o,
	output logic                    ram_we_n_o,
	output logic                    ram_oe_n_o,
	output logic                    mem_t_o,
	output logic [RAM_ADDR_W-1:0]   mem_adr_o,
	output logic [RAM_DATA_W-1:0]   mem_db_o,
	input  logic [RAM_DATA_W-1:0]   mem_db_i
);

	// Request path from decode to the sequencer
	logic                  req_valid;
	logic                  req_ready;
	logic                  req_we;
	logic [RAM_ADDR_W-1:0] req_adr;
	logic [2:0]            req_count;
	logic [BUS_DATA_W-1:0] req_wdat;
	logic                  cycle_end;

	// Results from the sequencer
	logic                  rd_byte_valid;
	logic [RAM_DATA_W-1:0] rd_byte;
	logic [1:0]            rd_lane;
	logic                  seq_done;
	logic                  seq_bad;

	bus_request_decode i_bus_request_decode (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.cs_i        (cs_i),
		.cyc_i       (cyc_i),
		.stb_i       (stb_i),
		.we_i        (we_i),
		.sel_i       (sel_i),
		.adr_i       (adr_i),
		.dat_i       (dat_i),
		.req_ready_i (req_ready),
		.req_valid_o (req_valid),
		.req_we_o    (req_we),
		.req_adr_o   (req_adr),
		.req_count_o (req_count),
		.req_wdat_o  (req_wdat),
		.cycle_end_o (cycle_end)
	);

	sram_byte_sequencer i_sram_byte_sequencer (
		.clk_i           (clk_i),
		.rst_i           (rst_i),
		.req_valid_i     (req_valid),
		.req_we_i        (req_we),
		.req_adr_i       (req_adr),
		.req_count_i     (req_count),
		.req_wdat_i      (req_wdat),
		.req_ready_o     (req_ready),
		.ram_ce_n_o      (ram_ce_n_o),
		.ram_we_n_o      (ram_we_n_o),
		.ram_oe_n_o      (ram_oe_n_o),
		.mem_t_o         (mem_t_o),
		.mem_adr_o       (mem_adr_o),
		.mem_db_o        (mem_db_o),
		.mem_db_i        (mem_db_i),
		.rd_byte_valid_o (rd_byte_valid),
		.rd_byte_o       (rd_byte),
		.rd_lane_o       (rd_lane),
		.seq_done_o      (seq_done),
		.seq_bad_o       (seq_bad)
	);

	read_word_assembly i_read_word_assembly (
		.clk_i           (clk_i),
		.rst_i           (rst_i),
		.rd_byte_valid_i (rd_byte_valid),
		.rd_byte_i       (rd_byte),
		.rd_lane_i       (rd_lane),
		.seq_done_i      (seq_done),
		.seq_bad_i       (seq_bad),
		.cycle_end_i     (cycle_end),
		.dat_o           (dat_o),
		.ack_o           (ack_o),
		.badram_o        (badram_o)
	);

endmodule

// ==== verif/sram_fault_model.sv ====
// Behavioral byte-wide asynchronous SRAM for the bridge testbench
// Resolves the shared data pins through the direction output
// Injectable stuck bits on read and transient write corruption

`timescale 1ns/1ps

module sram_fault_model import sram_bridge_pkg::*; (
	input  logic                    clk_i,
	input  logic                    ce_n_i,
	input  logic                    we_n_i,
	input  logic                    oe_n_i,
	input  logic                    t_i,
	input  logic [RAM_ADDR_W-1:0]   adr_i,
	input  logic [RAM_DATA_W-1:0]   db_i,
	output logic [RAM_DATA_W-1:0]   db_o
);

	logic [RAM_DATA_W-1:0] mem [0:(2**RAM_ADDR_W)-1];
	logic [RAM_DATA_W-1:0] stored;
	logic [RAM_DATA_W-1:0] rd_data;
	// Stuck bits act on the read path of one address
	logic [RAM_ADDR_W-1:0] stuck_adr;
	logic [RAM_DATA_W-1:0] stuck_mask;
	logic [RAM_DATA_W-1:0] stuck_val;
	// Writes to this address are inverted while the count lasts
	logic [RAM_ADDR_W-1:0] flaky_adr;
	int flaky_left;
	int write_count;
	int read_count;

	initial begin
		stuck_adr   = '0;
		stuck_mask  = '0;
		stuck_val   = '0;
		flaky_adr   = '0;
		flaky_left  = 0;
		write_count = 0;
		read_count  = 0;
	end

	assign stored  = mem[adr_i];
	assign rd_data = (adr_i == stuck_adr) ? ((stored & ~stuck_mask) | (stuck_val & stuck_mask))
	                                      : stored;

	// The pad carries the DUT data while it drives and the RAM output otherwise
	assign db_o = t_i ? ((!ce_n_i && !oe_n_i) ? rd_data : 8'h00) : db_i;

	// The RAM latches the byte on the rising edge of WE
	always @(posedge we_n_i) begin
		if (ce_n_i === 1'b0) begin
			write_count = write_count + 1;
			if (adr_i == flaky_adr && flaky_left > 0) begin
				mem[adr_i] = ~db_o;
				flaky_left = flaky_left - 1;
			end else begin
				mem[adr_i] = db_o;
			end
		end
	end

	// Every clock with CE and OE low counts as a read cycle
	always @(posedge clk_i) begin
		if (ce_n_i === 1'b0 && oe_n_i === 1'b0)
			read_count = read_count + 1;
	end

	task set_stuck(input logic [RAM_ADDR_W-1:0] adr, input logic [7:0] mask,
		       input logic [7:0] val);
		stuck_adr  = adr;
		stuck_mask = mask;
		stuck_val  = val;
	endtask

	task clear_stuck();
		stuck_mask = '0;
	endtask

	task set_transient(input logic [RAM_ADDR_W-1:0] adr, input int count);
		flaky_adr  = adr;
		flaky_left = count;
	endtask

endmodule

// ==== verif/tb_sram_bridge.sv ====
// Directed testbench for the bus to SRAM bridge
// Clock and reset, bus tasks, value check, reference byte memory
// Six tests covering full words, partial selects, faults and held cycles

`timescale 1ns/1ps

module tb_sram_bridge import sram_bridge_pkg::*; ();

	// Upper bound for every wait on the bus handshake
	localparam int TIMEOUT_CYCLES = 1000;

	logic                  clk;
	logic                  rst;
	logic                  cs;
	logic                  cyc;
	logic                  stb;
	logic                  we;
	logic [LANES-1:0]      sel;
	logic [BUS_DATA_W-1:0] adr;
	logic [BUS_DATA_W-1:0] wdat;
	logic [BUS_DATA_W-1:0] rdat;
	logic                  ack;
	logic                  badram;
	logic                  ram_ce_n;
	logic                  ram_we_n;
	logic                  ram_oe_n;
	logic                  mem_t;
	logic [RAM_ADDR_W-1:0] mem_adr;
	logic [RAM_DATA_W-1:0] mem_db_out;
	logic [RAM_DATA_W-1:0] mem_db_in;

	int error_count;
	int check_count;
	// Expected RAM contents indexed by byte address
	logic [7:0] ref_mem [int unsigned];

	sram_bridge_top i_sram_bridge_top (
		.clk_i      (clk),
		.rst_i      (rst),
		.cs_i       (cs),
		.cyc_i      (cyc),
		.stb_i      (stb),
		.we_i       (we),
		.sel_i      (sel),
		.adr_i      (adr),
		.dat_i      (wdat),
		.dat_o      (rdat),
		.ack_o      (ack),
		.badram_o   (badram),
		.ram_ce_n_o (ram_ce_n),
		.ram_we_n_o (ram_we_n),
		.ram_oe_n_o (ram_oe_n),
		.mem_t_o    (mem_t),
		.mem_adr_o  (mem_adr),
		.mem_db_o   (mem_db_out),
		.mem_db_i   (mem_db_in)
	);

	sram_fault_model i_sram_fault_model (
		.clk_i  (clk),
		.ce_n_i (ram_ce_n),
		.we_n_i (ram_we_n),
		.oe_n_i (ram_oe_n),
		.t_i    (mem_t),
		.adr_i  (mem_adr),
		.db_i   (mem_db_out),
		.db_o   (mem_db_in)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ============================================================
	// Helpers
	// ============================================================

	task check(input string name, input logic [31:0] expected, input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Lowest and highest selected lane with an empty span for an empty select
	function automatic void lane_span(input logic [3:0] s, output int lo, output int hi);
		lo = 4;
		hi = -1;
		for (int i = 0; i < 4; i++) begin
			if (s[i]) begin
				if (lo == 4)
					lo = i;
				hi = i;
			end
		end
	endfunction

	// Bits 18 to 2 pick the word and the lane picks the byte inside it
	function automatic int unsigned byte_addr(input logic [31:0] a, input int lane);
		return (a & 32'h0007_FFFC) + lane;
	endfunction

	function automatic logic [31:0] expected_read(input logic [31:0] a, input logic [3:0] s);
		int lo;
		int hi;
		logic [31:0] word;
		word = '0;
		lane_span(s, lo, hi);
		for (int l = lo; l <= hi; l++)
			word[l*8 +: 8] = ref_mem[byte_addr(a, l)];
		return word;
	endfunction

	task update_ref(input logic [31:0] a, input logic [3:0] s, input logic [31:0] d);
		int lo;
		int hi;
		lane_span(s, lo, hi);
		for (int l = lo; l <= hi; l++)
			ref_mem[byte_addr(a, l)] = d[l*8 +: 8];
	endtask

	function automatic int access_count();
		return i_sram_fault_model.write_count + i_sram_fault_model.read_count;
	endfunction

	// Upper bits are random too and the bridge must ignore them
	function automatic logic [31:0] random_adr();
		return $urandom & 32'hFFFF_FFFC;
	endfunction

	task wait_for_ack(input logic level, input string name);
		int cycles;
		cycles = 0;
		@(posedge clk);
		while (ack !== level && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (ack !== level) begin
			error_count++;
			$display("Timeout in %s: ack_o never reached %0b", name, level);
		end
	endtask

	task bus_start(input logic write, input logic [31:0] a, input logic [3:0] s,
		       input logic [31:0] d);
		@(posedge clk);
		cs   <= 1'b1;
		cyc  <= 1'b1;
		stb  <= 1'b1;
		we   <= write;
		sel  <= s;
		adr  <= a;
		wdat <= d;
	endtask

	// Called on the edge where the handshake was seen
	task bus_release();
		cs  <= 1'b0;
		cyc <= 1'b0;
		stb <= 1'b0;
		we  <= 1'b0;
		sel <= '0;
	endtask

	task bus_write(input logic [31:0] a, input logic [3:0] s, input logic [31:0] d,
		       input string name, output logic bad);
		bus_start(1'b1, a, s, d);
		wait_for_ack(1'b1, name);
		bad = badram;
		bus_release();
		wait_for_ack(1'b0, name);
		update_ref(a, s, d);
	endtask

	task bus_read(input logic [31:0] a, input logic [3:0] s, input string name,
		      output logic [31:0] d, output logic bad);
		bus_start(1'b0, a, s, '0);
		wait_for_ack(1'b1, name);
		d   = rdat;
		bad = badram;
		bus_release();
		wait_for_ack(1'b0, name);
	endtask

	task report_test(input string name, input int errors_before);
		$display("%s done, %0d error(s)", name, error_count - errors_before);
	endtask

	// ============================================================
	// Tests
	// ============================================================

	task test_reset_and_full_word();
		string name;
		int e0;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] rd;
		logic bad;
		name = "reset_and_full_word";
		e0   = error_count;
		check(name, 1, ram_ce_n);
		check(name, 1, ram_we_n);
		check(name, 1, ram_oe_n);
		check(name, 1, mem_t);
		check(name, 0, ack);
		check(name, 0, badram);
		check(name, 0, rdat);
		repeat (4) begin
			a = random_adr();
			d = $urandom;
			bus_write(a, 4'hF, d, name, bad);
			check(name, 0, bad);
			bus_read(a, 4'hF, name, rd, bad);
			check(name, d, rd);
			check(name, 0, bad);
		end
		report_test(name, e0);
	endtask

	task test_partial_selects();
		string name;
		int e0;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] d2;
		logic [31:0] rd;
		logic bad;
		name = "partial_selects";
		e0   = error_count;
		a    = random_adr();
		d    = $urandom;
		d2   = $urandom;
		bus_write(a, 4'hF, d, name, bad);
		// Only lane 2 changes
		bus_write(a, 4'b0100, d2, name, bad);
		bus_read(a, 4'hF, name, rd, bad);
		check(name, {d[31:24], d2[23:16], d[15:0]}, rd);
		// Lane 0 lies outside the span and reads as zero while lane 2 is a gap
		bus_read(a, 4'b1010, name, rd, bad);
		check(name, expected_read(a, 4'b1010), rd);
		bus_read(a, 4'b0010, name, rd, bad);
		check(name, {16'h0, d[15:8], 8'h0}, rd);
		// A write with a gap still writes the lanes between
		d = $urandom;
		bus_write(a, 4'b1001, d, name, bad);
		bus_read(a, 4'hF, name, rd, bad);
		check(name, d, rd);
		report_test(name, e0);
	endtask

	task test_zero_select();
		string name;
		int e0;
		int n0;
		logic [31:0] a;
		logic [31:0] rd;
		logic bad;
		name = "zero_select";
		e0   = error_count;
		a    = random_adr();
		bus_write(a, 4'hF, $urandom | 32'h1, name, bad);
		// A nonzero word sits on dat_o first so the empty read must clear it
		bus_read(a, 4'hF, name, rd, bad);
		check(name, expected_read(a, 4'hF), rd);
		n0 = access_count();
		bus_read(a, 4'h0, name, rd, bad);
		check(name, 0, rd);
		check(name, 0, bad);
		bus_write(a, 4'h0, $urandom, name, bad);
		check(name, 0, bad);
		check(name, n0, access_count());
		report_test(name, e0);
	endtask

	task test_transient_fault();
		string name;
		int e0;
		int w0;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] rd;
		logic bad;
		name = "transient_fault";
		e0   = error_count;
		a    = random_adr();
		d    = $urandom;
		i_sram_fault_model.set_transient(byte_addr(a, 2), 3);
		w0 = i_sram_fault_model.write_count;
		bus_write(a, 4'hF, d, name, bad);
		check(name, 0, bad);
		// Four bytes plus three repeated writes of lane 2
		check(name, 7, i_sram_fault_model.write_count - w0);
		bus_read(a, 4'hF, name, rd, bad);
		check(name, d, rd);
		report_test(name, e0);
	endtask

	task test_stuck_bit();
		string name;
		int e0;
		int w0;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] d;
		logic [31:0] rd;
		logic bad;
		name = "stuck_bit";
		e0   = error_count;
		a    = random_adr();
		b    = a ^ 32'h0000_0100;
		d    = $urandom;
		// Bit 0 of lane 1 reads back inverted from what is written
		i_sram_fault_model.set_stuck(byte_addr(a, 1), 8'h01, {7'h0, ~d[8]});
		w0 = i_sram_fault_model.write_count;
		bus_write(a, 4'hF, d, name, bad);
		check(name, 1, bad);
		check(name, 3 + 1 + MAX_RETRIES, i_sram_fault_model.write_count - w0);
		check(name, 0, badram);
		i_sram_fault_model.clear_stuck();
		d = $urandom;
		bus_write(b, 4'hF, d, name, bad);
		check(name, 0, bad);
		bus_read(b, 4'hF, name, rd, bad);
		check(name, d, rd);
		check(name, 0, bad);
		report_test(name, e0);
	endtask

	task test_held_cycle();
		string name;
		int e0;
		int n0;
		logic [31:0] a;
		logic [31:0] d;
		logic bad;
		name = "held_cycle";
		e0   = error_count;
		a    = random_adr();
		d    = $urandom;
		bus_write(a, 4'hF, d, name, bad);
		bus_start(1'b0, a, 4'hF, '0);
		wait_for_ack(1'b1, name);
		check(name, d, rdat);
		n0 = access_count();
		// The master keeps the cycle open
		repeat (10) begin
			@(posedge clk);
			check(name, 1, ack);
			check(name, 1, ram_ce_n);
		end
		check(name, n0, access_count());
		bus_release();
		wait_for_ack(1'b0, name);
		check(name, 0, badram);
		report_test(name, e0);
	endtask

	// ============================================================
	// Main sequence
	// ============================================================

	initial begin
		error_count = 0;
		check_count = 0;
		void'($urandom(32'h7773_adc6));
		rst  = 1'b1;
		cs   = 1'b0;
		cyc  = 1'b0;
		stb  = 1'b0;
		we   = 1'b0;
		sel  = '0;
		adr  = '0;
		wdat = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		test_reset_and_full_word();
		test_partial_selects();
		test_zero_select();
		test_transient_fault();
		test_stuck_bit();
		test_held_cycle();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== list.f ====
source/sram_bridge_pkg.sv
source/bus_request_decode.sv
source/sram_byte_sequencer.sv
source/read_word_assembly.sv
source/sram_bridge_top.sv
verif/sram_fault_model.sv
verif/tb_sram_bridge.sv

// ==== Bender.yml ====
package:
  name: sram_bridge

sources:
  # Package first, then the blocks, then the top level
  - source/sram_bridge_pkg.sv
  - source/bus_request_decode.sv
  - source/sram_byte_sequencer.sv
  - source/read_word_assembly.sv
  - source/sram_bridge_top.sv

  # RAM model and testbench
  - target: test
    files:
      - verif/sram_fault_model.sv
      - verif/tb_sram_bridge.sv
